//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

    // datapath and index widths
    localparam int xlen       = 64;
    localparam int csr_addr_w = 12;

    // machine CSR addresses
    localparam logic [csr_addr_w-1:0] csr_mstatus   = 12'h300;
    localparam logic [csr_addr_w-1:0] csr_misa      = 12'h301;
    localparam logic [csr_addr_w-1:0] csr_mie       = 12'h304;
    localparam logic [csr_addr_w-1:0] csr_mtvec     = 12'h305;
    localparam logic [csr_addr_w-1:0] csr_mscratch  = 12'h340;
    localparam logic [csr_addr_w-1:0] csr_mepc      = 12'h341;
    localparam logic [csr_addr_w-1:0] csr_mcause    = 12'h342;
    localparam logic [csr_addr_w-1:0] csr_mip       = 12'h344;
    localparam logic [csr_addr_w-1:0] csr_mcycle    = 12'hb00;
    localparam logic [csr_addr_w-1:0] csr_minstret  = 12'hb02;
    localparam logic [csr_addr_w-1:0] csr_mvendorid = 12'hf11;
    localparam logic [csr_addr_w-1:0] csr_marchid   = 12'hf12;
    localparam logic [csr_addr_w-1:0] csr_mimpid    = 12'hf13;
    localparam logic [csr_addr_w-1:0] csr_mhartid   = 12'hf14;

    // mstatus fields
    localparam int mstatus_mie  = 3;
    localparam int mstatus_mpie = 7;
    localparam int mpp_lo       = 11;
    localparam int mpp_hi       = 12;
    localparam int fs_lo        = 13;
    localparam int fs_hi        = 14;
    localparam int xs_lo        = 15;
    localparam int xs_hi        = 16;
    localparam int sd_bit       = 63;

    // timer interrupt position in mip and mie
    localparam int mtip_bit = 7;

    // MXL = 2, I extension only
    localparam logic [xlen-1:0] misa_value    = 64'h8000_0000_0000_0100;
    localparam logic [xlen-1:0] marchid_value = 64'd1;

    // trap causes
    localparam logic [xlen-1:0] cause_ecall_m    = 64'd11;
    localparam logic [xlen-1:0] cause_breakpoint = 64'd3;
    localparam logic [xlen-1:0] cause_m_timer    = 64'h8000_0000_0000_0007;

    // SYSTEM opcode and the fixed privileged encodings
    localparam logic [6:0]  opcode_system = 7'b111_0011;
    localparam logic [31:0] inst_ecall    = 32'h0000_0073;
    localparam logic [31:0] inst_ebreak   = 32'h0010_0073;
    localparam logic [31:0] inst_mret     = 32'h3020_0073;

    typedef enum logic [1:0] {
        op_none = 2'b00,
        op_rw   = 2'b01,
        op_rs   = 2'b10,
        op_rc   = 2'b11
    } csr_op_e;

endpackage

`default_nettype wire

//--- rtl/csr_cmd_if.sv
`timescale 1ns/10ps
`default_nettype none

interface csr_cmd_if;
    import csr_pkg::*;

    logic                  valid;
    csr_op_e               op;
    logic [csr_addr_w-1:0] index;
    // operand after the rs1 / zimm choice
    logic [xlen-1:0]       wdata;
    logic                  ecall;
    logic                  ebreak;
    logic                  mret;

    modport decoder (
        output valid,
        output op,
        output index,
        output wdata,
        output ecall,
        output ebreak,
        output mret
    );

    modport csr_file (
        input valid,
        input op,
        input index,
        input wdata,
        input ecall,
        input ebreak,
        input mret
    );

endinterface

`default_nettype wire

//--- rtl/csr_decode.sv
`timescale 1ns/10ps
`default_nettype none

module csr_decode (
    input  logic [31:0]              inst,
    input  logic                     inst_valid,
    input  logic [csr_pkg::xlen-1:0] rs1_data,
    csr_cmd_if.decoder               cmd
);
    import csr_pkg::*;

    logic       is_system;
    logic [2:0] funct3;
    logic       use_imm;
    logic [4:0] src_field;

    assign is_system = (inst[6:0] == opcode_system);
    assign funct3    = inst[14:12];
    assign src_field = inst[19:15];

    // funct3[2] selects the zimm forms
    assign use_imm = funct3[2];

    always_comb begin
        cmd.op = op_none;
        if (is_system) begin
            case (funct3[1:0])
                2'b01: begin
                    cmd.op = op_rw;
                end
                // set / clear with x0 or zimm 0 only reads
                2'b10: begin
                    cmd.op = (src_field != 5'd0) ? op_rs : op_none;
                end
                2'b11: begin
                    cmd.op = (src_field != 5'd0) ? op_rc : op_none;
                end
                default: begin
                    cmd.op = op_none;
                end
            endcase
        end
    end

    assign cmd.valid = inst_valid;
    assign cmd.index = inst[31:20];
    assign cmd.wdata = use_imm ? {{(xlen-5){1'b0}}, src_field} : rs1_data;

    // full-word compare against the fixed encodings
    assign cmd.ecall  = (inst == inst_ecall);
    assign cmd.ebreak = (inst == inst_ebreak);
    assign cmd.mret   = (inst == inst_mret);

endmodule

`default_nettype wire

//--- rtl/clint_timer.sv
`timescale 1ns/10ps
`default_nettype none

module clint_timer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     mtimecmp_we,
    input  logic [csr_pkg::xlen-1:0] mtimecmp_wdata,
    output logic                     mtip
);
    import csr_pkg::*;

    logic [xlen-1:0] mtime;
    logic [xlen-1:0] mtimecmp;
    logic            cmp_hit;

    // unsigned compare
    assign cmp_hit = (mtime >= mtimecmp);

    // free-running time base
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + xlen'(1);
        end
    end

    // all ones after reset keeps the interrupt quiet
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp <= '1;
        end else if (mtimecmp_we) begin
            mtimecmp <= mtimecmp_wdata;
        end
    end

    // level shows up one cycle after mtime reaches the compare value
    always_ff @(posedge clk) begin
        if (rst) begin
            mtip <= 1'b0;
        end else begin
            mtip <= cmp_hit;
        end
    end

endmodule

`default_nettype wire

//--- rtl/csr_file.sv
`timescale 1ns/10ps
`default_nettype none

module csr_file (
    input  logic                     clk,
    input  logic                     rst,
    csr_cmd_if.csr_file              cmd,
    input  logic                     take_irq,
    input  logic [csr_pkg::xlen-1:0] inst_addr,
    input  logic                     mtip,
    output logic [csr_pkg::xlen-1:0] csr_read,
    output logic                     csr_trap,
    output logic [csr_pkg::xlen-1:0] csr_nxt_pc
);
    import csr_pkg::*;

    logic [xlen-1:0] mstatus;
    logic [xlen-1:0] mtvec;
    logic [xlen-1:0] mepc;
    logic [xlen-1:0] mcause;
    logic [xlen-1:0] mie;
    logic [xlen-1:0] mscratch;
    logic [xlen-1:0] mcycle;
    logic [xlen-1:0] minstret;
    logic [xlen-1:0] mip;

    logic [xlen-1:0] old_val;
    logic [xlen-1:0] new_val;
    logic [xlen-1:0] mstatus_wval;
    logic [xlen-1:0] trap_cause;

    logic wr_en;
    logic trap_en;
    logic ret_en;
    logic wr_mstatus;
    logic wr_mtvec;
    logic wr_mepc;
    logic wr_mcause;
    logic wr_mie;
    logic wr_mscratch;
    logic wr_mcycle;
    logic wr_minstret;

    // MTIP mirrors the timer level and is the only mip bit
    assign mip = {{(xlen-1){1'b0}}, mtip} << mtip_bit;

    // old value of the indexed CSR
    always_comb begin
        case (cmd.index)
            csr_mstatus:   old_val = mstatus;
            csr_misa:      old_val = misa_value;
            csr_mie:       old_val = mie;
            csr_mtvec:     old_val = mtvec;
            csr_mscratch:  old_val = mscratch;
            csr_mepc:      old_val = mepc;
            csr_mcause:    old_val = mcause;
            csr_mip:       old_val = mip;
            csr_mcycle:    old_val = mcycle;
            csr_minstret:  old_val = minstret;
            csr_marchid:   old_val = marchid_value;
            // mvendorid, mimpid, mhartid and unknown indexes
            default:       old_val = '0;
        endcase
    end

    always_comb begin
        case (cmd.op)
            op_rw:   new_val = cmd.wdata;
            op_rs:   new_val = old_val | cmd.wdata;
            op_rc:   new_val = old_val & ~cmd.wdata;
            default: new_val = old_val;
        endcase
    end

    // SD summarises dirty FS / XS
    always_comb begin
        mstatus_wval = new_val;
        mstatus_wval[sd_bit] = (new_val[fs_hi:fs_lo] == 2'b11) ||
                               (new_val[xs_hi:xs_lo] == 2'b11);
    end

    // ecall beats ebreak beats the timer
    always_comb begin
        if (cmd.ecall) begin
            trap_cause = cause_ecall_m;
        end else if (cmd.ebreak) begin
            trap_cause = cause_breakpoint;
        end else begin
            trap_cause = cause_m_timer;
        end
    end

    assign wr_en   = cmd.valid && (cmd.op != op_none);
    assign trap_en = cmd.valid && (cmd.ecall || cmd.ebreak || take_irq);
    assign ret_en  = cmd.valid && cmd.mret;

    assign wr_mstatus  = wr_en && (cmd.index == csr_mstatus);
    assign wr_mtvec    = wr_en && (cmd.index == csr_mtvec);
    assign wr_mepc     = wr_en && (cmd.index == csr_mepc);
    assign wr_mcause   = wr_en && (cmd.index == csr_mcause);
    assign wr_mie      = wr_en && (cmd.index == csr_mie);
    assign wr_mscratch = wr_en && (cmd.index == csr_mscratch);
    assign wr_mcycle   = wr_en && (cmd.index == csr_mcycle);
    assign wr_minstret = wr_en && (cmd.index == csr_minstret);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus <= '0;
        end else if (wr_mstatus) begin
            mstatus <= mstatus_wval;
        end else if (trap_en) begin
            mstatus[mstatus_mpie]  <= mstatus[mstatus_mie];
            mstatus[mstatus_mie]   <= 1'b0;
            mstatus[mpp_hi:mpp_lo] <= 2'b11;
        end else if (ret_en) begin
            mstatus[mstatus_mie]   <= mstatus[mstatus_mpie];
            mstatus[mstatus_mpie]  <= 1'b1;
            mstatus[mpp_hi:mpp_lo] <= 2'b00;
        end
    end

    // direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= '0;
        end else if (wr_mtvec) begin
            mtvec <= new_val & ~xlen'(3);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc   <= '0;
            mcause <= '0;
        end else begin
            if (wr_mepc) begin
                mepc <= new_val;
            end else if (trap_en) begin
                mepc <= inst_addr;
            end
            if (wr_mcause) begin
                mcause <= new_val;
            end else if (trap_en) begin
                mcause <= trap_cause;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie      <= '0;
            mscratch <= '0;
        end else begin
            if (wr_mie) begin
                mie <= new_val & (xlen'(1) << mtip_bit);
            end
            if (wr_mscratch) begin
                mscratch <= new_val;
            end
        end
    end

    // a CSR write replaces the counter increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle   <= '0;
            minstret <= '0;
        end else begin
            mcycle <= wr_mcycle ? new_val : mcycle + xlen'(1);
            if (wr_minstret) begin
                minstret <= new_val;
            end else if (cmd.valid) begin
                minstret <= minstret + xlen'(1);
            end
        end
    end

    assign csr_read   = old_val;
    assign csr_trap   = mstatus[mstatus_mie] && mie[mtip_bit] && mip[mtip_bit];
    assign csr_nxt_pc = trap_en ? mtvec : mepc;

    // command rule shared with csr_decode
    a_cmd_exclusive: assert property (
        @(posedge clk) disable iff (rst)
        cmd.valid |-> $onehot0({cmd.op != op_none, cmd.ecall, cmd.ebreak, cmd.mret})
    ) else $error("csr_file: more than one of CSR op, ecall, ebreak, mret");

endmodule

`default_nettype wire

//--- rtl/machine_csr_unit.sv
`timescale 1ns/10ps
`default_nettype none

module machine_csr_unit (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inst_valid,
    input  logic [31:0]              inst,
    input  logic [csr_pkg::xlen-1:0] rs1_data,
    input  logic [csr_pkg::xlen-1:0] inst_addr,
    input  logic                     take_irq,
    input  logic                     mtimecmp_we,
    input  logic [csr_pkg::xlen-1:0] mtimecmp_wdata,
    output logic [csr_pkg::xlen-1:0] csr_read,
    output logic                     csr_trap,
    output logic [csr_pkg::xlen-1:0] csr_nxt_pc
);

    logic mtip;

    csr_cmd_if cmd_if ();

    csr_decode csr_decode_i (
        .inst       (inst),
        .inst_valid (inst_valid),
        .rs1_data   (rs1_data),
        .cmd        (cmd_if.decoder)
    );

    clint_timer clint_timer_i (
        .clk            (clk),
        .rst            (rst),
        .mtimecmp_we    (mtimecmp_we),
        .mtimecmp_wdata (mtimecmp_wdata),
        .mtip           (mtip)
    );

    csr_file csr_file_i (
        .clk        (clk),
        .rst        (rst),
        .cmd        (cmd_if.csr_file),
        .take_irq   (take_irq),
        .inst_addr  (inst_addr),
        .mtip       (mtip),
        .csr_read   (csr_read),
        .csr_trap   (csr_trap),
        .csr_nxt_pc (csr_nxt_pc)
    );

endmodule

`default_nettype wire

//--- verif/machine_csr_unit_tb.sv
`timescale 1ns/10ps
`default_nettype none

module machine_csr_unit_tb;
    import csr_pkg::*;

    localparam int          rmw_rounds  = 40;
    localparam int          wait_limit  = 200;
    localparam logic [31:0] nop_word    = 32'h0000_0013;
    localparam logic [31:0] ecall_word  = 32'h0000_0073;
    localparam logic [31:0] ebreak_word = 32'h0010_0073;
    localparam logic [31:0] mret_word   = 32'h3020_0073;

    logic        clk;
    logic        rst;
    logic        inst_valid;
    logic [31:0] inst;
    logic [63:0] rs1_data;
    logic [63:0] inst_addr;
    logic        take_irq;
    logic        mtimecmp_we;
    logic [63:0] mtimecmp_wdata;
    logic [63:0] csr_read;
    logic        csr_trap;
    logic [63:0] csr_nxt_pc;

    // expected CSR contents by address
    logic [63:0] shadow [0:4095];
    logic        read_check_en;
    logic [63:0] exp_read;
    logic [63:0] exp_pc;
    string       test_name;
    integer      seed;
    int          check_count;
    int          error_count;
    int          test_errors_at_start;
    int          tests_run;
    int          tests_failed;

    machine_csr_unit machine_csr_unit_i (.*);

    always #10 clk = ~clk;

    // sample 1 ns ahead of the rising edge
    always begin
        @(negedge clk);
        #9;
        if (!rst) begin
            check_count++;
            assert (csr_nxt_pc === exp_pc) else begin
                $display("[FAIL] %s: csr_nxt_pc expected %h actual %h",
                         test_name, exp_pc, csr_nxt_pc);
                error_count++;
            end
            if (read_check_en) begin
                check_count++;
                assert (csr_read === exp_read) else begin
                    $display("[FAIL] %s: csr_read expected %h actual %h",
                             test_name, exp_read, csr_read);
                    error_count++;
                end
            end
        end
    end

    // expected register value after a CSR instruction
    function automatic logic [63:0] expected_csr_write(input logic [1:0] op,
            input logic [63:0] old, input logic [63:0] operand, input logic [11:0] idx);
        logic [63:0] val;
        case (op)
            2'd1:    val = operand;
            2'd2:    val = old | operand;
            2'd3:    val = old & ~operand;
            default: return old;
        endcase
        case (idx)
            csr_mtvec:   val = val & ~64'd3;
            csr_mie:     val = val & (64'd1 << 7);
            csr_mstatus: val[63] = (val[14:13] == 2'b11) || (val[16:15] == 2'b11);
            csr_mscratch, csr_mepc, csr_mcause, csr_mcycle, csr_minstret: ;
            // read-only or unimplemented
            default:     val = old;
        endcase
        return val;
    endfunction

    // csrrs / csrrc with x0 or zimm 0 only read
    function automatic logic [1:0] effective_op(input logic [2:0] funct3, input logic [4:0] src);
        if (funct3[1:0] != 2'd1 && src == 5'd0) begin
            return 2'd0;
        end
        return funct3[1:0];
    endfunction

    function automatic logic [31:0] encode_csr(input logic [11:0] idx, input logic [4:0] src,
                                               input logic [2:0] funct3);
        return {idx, src, funct3, 5'd1, 7'b111_0011};
    endfunction

    function automatic logic [11:0] rmw_target(input int k);
        case (k)
            0:       return csr_mscratch;
            1:       return csr_mepc;
            2:       return csr_mtvec;
            3:       return csr_mie;
            default: return csr_mstatus;
        endcase
    endfunction

    function automatic void apply_trap(input logic [63:0] addr, input logic [63:0] cause);
        shadow[csr_mepc]           = addr;
        shadow[csr_mcause]         = cause;
        shadow[csr_mstatus][7]     = shadow[csr_mstatus][3];
        shadow[csr_mstatus][3]     = 1'b0;
        shadow[csr_mstatus][12:11] = 2'b11;
    endfunction

    function automatic void apply_mret();
        shadow[csr_mstatus][3]     = shadow[csr_mstatus][7];
        shadow[csr_mstatus][7]     = 1'b1;
        shadow[csr_mstatus][12:11] = 2'b00;
    endfunction

    task automatic drive_inst(input logic [31:0] word, input logic [63:0] operand,
                              input logic [63:0] addr, input logic irq,
                              input logic check_read, input logic [63:0] expected_read);
        @(negedge clk);
        inst_valid    = 1'b1;
        inst          = word;
        rs1_data      = operand;
        inst_addr     = addr;
        take_irq      = irq;
        read_check_en = check_read;
        exp_read      = expected_read;
        // trap cycles redirect to mtvec
        if (irq || word == ecall_word || word == ebreak_word) begin
            exp_pc = shadow[csr_mtvec];
        end else begin
            exp_pc = shadow[csr_mepc];
        end
    endtask

    task automatic idle_cycle();
        @(negedge clk);
        inst_valid    = 1'b0;
        inst          = '0;
        take_irq      = 1'b0;
        read_check_en = 1'b0;
        exp_pc        = shadow[csr_mepc];
    endtask

    task automatic csr_access(input logic [11:0] idx, input logic [2:0] funct3,
                              input logic [4:0] src, input logic [63:0] operand);
        logic [63:0] old;
        logic [63:0] wdata;
        old   = shadow[idx];
        wdata = funct3[2] ? {59'd0, src} : operand;
        drive_inst(encode_csr(idx, src, funct3), operand, '0, 1'b0, 1'b1, old);
        shadow[idx] = expected_csr_write(effective_op(funct3, src), old, wdata, idx);
    endtask

    task automatic read_back(input logic [11:0] idx);
        csr_access(idx, 3'b010, 5'd0, '0);
    endtask

    // read, try a write, read again
    task automatic probe_fixed(input logic [11:0] idx);
        read_back(idx);
        csr_access(idx, 3'b001, 5'd1, {$random(seed), $random(seed)});
        read_back(idx);
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("[FAIL] %s: %s expected %h actual %h", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic start_test(input string name);
        test_name            = name;
        test_errors_at_start = error_count;
    endtask

    task automatic finish_test();
        idle_cycle();
        tests_run++;
        if (error_count == test_errors_at_start) begin
            $display("test %s: ok", test_name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", test_name, error_count - test_errors_at_start);
        end
    endtask

    initial begin
        logic [63:0] base;
        logic [63:0] addr;
        logic [11:0] idx;
        logic [2:0]  f3;
        int          n;

        seed           = 32'h5d66_e148;
        clk            = 1'b0;
        rst            = 1'b1;
        inst_valid     = 1'b0;
        inst           = '0;
        rs1_data       = '0;
        inst_addr      = '0;
        take_irq       = 1'b0;
        mtimecmp_we    = 1'b0;
        mtimecmp_wdata = '0;
        read_check_en  = 1'b0;
        exp_read       = '0;
        exp_pc         = '0;
        test_name      = "reset";
        check_count    = 0;
        error_count    = 0;
        tests_run      = 0;
        tests_failed   = 0;
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = '0;
        end
        shadow[csr_misa]    = (64'd2 << 62) | (64'd1 << 8);
        shadow[csr_marchid] = 64'd1;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("rmw");
        for (int i = 0; i < rmw_rounds; i++) begin
            idx = rmw_target({$random(seed)} % 5);
            f3  = {1'($random(seed)), 2'(({$random(seed)} % 3) + 1)};
            csr_access(idx, f3, 5'($random(seed)), {$random(seed), $random(seed)});
            read_back(idx);
        end
        // dirty FS, then dirty XS, then both clean again
        csr_access(csr_mstatus, 3'b001, 5'd1, 64'h6000);
        read_back(csr_mstatus);
        csr_access(csr_mstatus, 3'b001, 5'd1, 64'h1_8000);
        read_back(csr_mstatus);
        csr_access(csr_mstatus, 3'b011, 5'd1, 64'h1_e000);
        read_back(csr_mstatus);
        finish_test();

        start_test("constants");
        probe_fixed(csr_misa);
        probe_fixed(csr_mvendorid);
        probe_fixed(csr_marchid);
        probe_fixed(csr_mimpid);
        probe_fixed(csr_mhartid);
        probe_fixed(12'h000);
        probe_fixed(12'h7c0);
        probe_fixed(12'h3a0);
        finish_test();

        start_test("ecall_ebreak");
        csr_access(csr_mtvec, 3'b001, 5'd1, 64'h8000_0103);
        csr_access(csr_mstatus, 3'b101, 5'd8, '0);
        for (int k = 0; k < 2; k++) begin
            addr = {$random(seed), $random(seed)} & ~64'd3;
            drive_inst((k == 0) ? ecall_word : ebreak_word, '0, addr, 1'b0, 1'b1, '0);
            apply_trap(addr, (k == 0) ? 64'd11 : 64'd3);
            read_back(csr_mepc);
            read_back(csr_mcause);
            read_back(csr_mstatus);
            drive_inst(mret_word, '0, '0, 1'b0, 1'b1, '0);
            apply_mret();
            read_back(csr_mstatus);
        end
        finish_test();

        start_test("timer");
        idle_cycle();
        mtimecmp_we    = 1'b1;
        mtimecmp_wdata = 64'd16;
        idle_cycle();
        mtimecmp_we = 1'b0;
        csr_access(csr_mie, 3'b010, 5'd2, 64'h80);
        csr_access(csr_mstatus, 3'b110, 5'd8, '0);
        for (n = 0; n < wait_limit && csr_trap !== 1'b1; n++) begin
            idle_cycle();
        end
        if (csr_trap !== 1'b1) begin
            $display("timeout: csr_trap did not rise within %0d cycles of enabling the timer",
                     wait_limit);
            error_count++;
        end else begin
            shadow[csr_mip] = 64'h80;
            read_back(csr_mip);
            addr = {$random(seed), $random(seed)} & ~64'd3;
            drive_inst(nop_word, '0, addr, 1'b1, 1'b1, '0);
            apply_trap(addr, 64'h8000_0000_0000_0007);
            read_back(csr_mcause);
            read_back(csr_mepc);
            check_value("csr_trap with MIE cleared", 64'd0, {63'd0, csr_trap});
        end
        finish_test();

        start_test("counters");
        // the first read retires as well
        drive_inst(encode_csr(csr_minstret, 5'd0, 3'b010), '0, '0, 1'b0, 1'b0, '0);
        #1 base = csr_read;
        n = 3 + {$random(seed)} % 6;
        repeat (n) begin
            drive_inst(nop_word, '0, '0, 1'b0, 1'b0, '0);
            idle_cycle();
        end
        shadow[csr_minstret] = base + 64'(n) + 64'd1;
        read_back(csr_minstret);
        drive_inst(encode_csr(csr_mcycle, 5'd0, 3'b010), '0, '0, 1'b0, 1'b0, '0);
        #1 base = csr_read;
        n = 2 + {$random(seed)} % 5;
        repeat (n - 1) idle_cycle();
        shadow[csr_mcycle] = base + 64'(n);
        read_back(csr_mcycle);
        // counting resumes from a written value
        base = {16'h0, 16'($random(seed)), 32'($random(seed))};
        drive_inst(encode_csr(csr_mcycle, 5'd1, 3'b001), base, '0, 1'b0, 1'b0, '0);
        shadow[csr_mcycle] = base;
        read_back(csr_mcycle);
        repeat (3) idle_cycle();
        shadow[csr_mcycle] = base + 64'd4;
        read_back(csr_mcycle);
        drive_inst(encode_csr(csr_minstret, 5'd1, 3'b001), base, '0, 1'b0, 1'b0, '0);
        shadow[csr_minstret] = base;
        read_back(csr_minstret);
        repeat (2) idle_cycle();
        drive_inst(nop_word, '0, '0, 1'b0, 1'b0, '0);
        shadow[csr_minstret] = base + 64'd2;
        read_back(csr_minstret);
        finish_test();

        $display("tests run %0d, tests failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- machine_csr_unit.f
rtl/csr_pkg.sv
rtl/csr_cmd_if.sv
rtl/csr_decode.sv
rtl/clint_timer.sv
rtl/csr_file.sv
rtl/machine_csr_unit.sv
verif/machine_csr_unit_tb.sv

//--- Bender.yml
package:
  name: machine_csr_unit

sources:
  - rtl/csr_pkg.sv
  - rtl/csr_cmd_if.sv
  - rtl/csr_decode.sv
  - rtl/clint_timer.sv
  - rtl/csr_file.sv
  - rtl/machine_csr_unit.sv
  - target: test
    files:
      - verif/machine_csr_unit_tb.sv
